/* Bender.yml */
package:
  name: i3c_target

sources:
  - files:
      - hw/i3c_target_pkg.sv
      - hw/target_config.sv
      - hw/bus_monitor.sv
      - hw/addr_receiver.sv
      - hw/i3c_target.sv
  - target: test
    files:
      - dv/i3c_target_props.sv
      - dv/tb_i3c_target.sv

/* build.f */
hw/i3c_target_pkg.sv
hw/target_config.sv
hw/bus_monitor.sv
hw/addr_receiver.sv
hw/i3c_target.sv
dv/i3c_target_props.sv
dv/tb_i3c_target.sv

/* dv/i3c_target_props.sv */
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions on the I3C target top level
// Bus condition exclusivity, address valid pulse and SDA release rules
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module i3c_target_props (
  input logic clk_i,
  input logic rst_i,
  input logic enable_i,
  input logic sda_o,
  input logic bus_start_o,
  input logic bus_rstart_o,
  input logic bus_stop_o,
  input logic bus_addr_valid_o
);

  int unsigned fail_cnt = 0;
  logic        started_q;

  // Set by the first START or repeated START after reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      started_q <= 1'b0;
    end else if (bus_start_o || bus_rstart_o) begin
      started_q <= 1'b1;
    end
  end

  cond_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0({bus_start_o, bus_rstart_o, bus_stop_o}))
    else begin
      $error("More than one bus condition pulse in the same cycle");
      fail_cnt++;
    end

  valid_single: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_addr_valid_o |=> !bus_addr_valid_o)
    else begin
      $error("bus_addr_valid_o held high for more than one cycle");
      fail_cnt++;
    end

  sda_idle_until_start: assert property (@(posedge clk_i) disable iff (rst_i)
      !started_q |-> sda_o)
    else begin
      $error("sda_o driven low before the first START");
      fail_cnt++;
    end

  // Disable takes effect one cycle after the config register drops it
  sda_released_disabled: assert property (@(posedge clk_i) disable iff (rst_i)
      !enable_i |=> sda_o)
    else begin
      $error("sda_o driven low while the target is disabled");
      fail_cnt++;
    end

endmodule

bind i3c_target i3c_target_props i_i3c_target_props (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .enable_i        (cfg.enable),
  .sda_o           (sda_o),
  .bus_start_o     (bus_start_o),
  .bus_rstart_o    (bus_rstart_o),
  .bus_stop_o      (bus_stop_o),
  .bus_addr_valid_o(bus_addr_valid_o)
);

/* dv/tb_i3c_target.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the I3C target
// Clock, reset, bus driver tasks, ACK reference model, checks, watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_i3c_target;

  localparam int unsigned PhaseCycles = 8;
  localparam int unsigned ClkPeriodNs = 40;
  localparam int unsigned NumTransfers = 36;
  localparam int unsigned PhasesPerTransfer = 36;
  localparam int unsigned TimeoutNs =
      NumTransfers * PhasesPerTransfer * PhaseCycles * ClkPeriodNs * 2;

  logic clk_i, rst_i, scl_i, sda_i, cfg_we_i;
  logic [i3c_target_pkg::CfgWidth-1:0] cfg_wdata_i;
  logic scl_o, sda_o, bus_start_o, bus_rstart_o, bus_stop_o, bus_addr_valid_o;
  logic [i3c_target_pkg::ByteWidth-1:0] bus_addr_o;

  // Reference model state
  logic       m_en;
  logic [6:0] m_sta;
  logic       m_valid;

  int unsigned n_start, n_rstart, n_stop, n_valid;
  int unsigned errors, checks, tests;
  logic [7:0] last_addr;
  logic [7:0] data;
  logic [6:0] sta;
  integer seed;

  i3c_target i_i3c_target (.*);

  always #20 clk_i = ~clk_i;

  // Pulses are counted half a cycle after they change
  always @(negedge clk_i) begin
    if (bus_start_o) n_start++;
    if (bus_rstart_o) n_rstart++;
    if (bus_stop_o) n_stop++;
    if (bus_addr_valid_o) begin
      n_valid++;
      last_addr = bus_addr_o;
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: the bus transfers did not complete in time");
    $display("Testbench failed");
    $finish;
  end

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // ACK on broadcast or on a valid static address match
  function automatic logic model_ack(input logic [7:0] b);
    if (!m_en) return 1'b0;
    return (b[7:1] == 7'h7E) || (m_valid && (b[7:1] == m_sta));
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
    end
  endtask

  task automatic expect_counts(input int unsigned s, input int unsigned r,
                               input int unsigned p);
    expect_equal("bus_start_o pulses", n_start, s);
    expect_equal("bus_rstart_o pulses", n_rstart, r);
    expect_equal("bus_stop_o pulses", n_stop, p);
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic write_cfg(input logic en, input logic [6:0] sa, input logic valid);
    logic [i3c_target_pkg::CfgWidth-1:0] word;
    word = '0;
    word[i3c_target_pkg::CfgEnBit] = en;
    word[i3c_target_pkg::CfgStaAddrLsb +: i3c_target_pkg::AddrWidth] = sa;
    word[i3c_target_pkg::CfgStaValidBit] = valid;
    @(negedge clk_i);
    cfg_we_i = 1'b1;
    cfg_wdata_i = word;
    @(negedge clk_i);
    cfg_we_i = 1'b0;
    m_en = en;
    m_sta = sa;
    m_valid = valid;
  endtask

  // Repeated START when SCL is low at entry
  task automatic send_start();
    if (!scl_i) begin
      sda_i = 1'b1;
      wait_cycles(PhaseCycles);
      scl_i = 1'b1;
      wait_cycles(PhaseCycles);
    end
    sda_i = 1'b0;
    wait_cycles(PhaseCycles);
    scl_i = 1'b0;
    wait_cycles(PhaseCycles);
  endtask

  task automatic send_stop();
    sda_i = 1'b0;
    wait_cycles(PhaseCycles);
    scl_i = 1'b1;
    wait_cycles(PhaseCycles);
    sda_i = 1'b1;
    wait_cycles(PhaseCycles);
  endtask

  task automatic send_byte(input logic [7:0] b, output logic sda_seen);
    for (int i = 7; i >= 0; i--) begin
      sda_i = b[i];
      wait_cycles(PhaseCycles);
      scl_i = 1'b1;
      wait_cycles(PhaseCycles);
      scl_i = 1'b0;
      wait_cycles(PhaseCycles);
    end
    // SDA released on the ninth clock for the target's ACK
    sda_i = 1'b1;
    wait_cycles(PhaseCycles);
    scl_i = 1'b1;
    wait_cycles(PhaseCycles / 2);
    sda_seen = sda_o;
    wait_cycles(PhaseCycles / 2);
    scl_i = 1'b0;
    wait_cycles(PhaseCycles);
  endtask

  task automatic check_byte(input logic [7:0] b);
    int unsigned valid_before;
    logic        sda_seen;
    valid_before = n_valid;
    send_byte(b, sda_seen);
    expect_equal("sda_o", sda_seen, !model_ack(b));
    expect_equal("scl_o", scl_o, 1'b1);
    expect_equal("bus_addr_valid_o pulses", n_valid - valid_before, m_en ? 1 : 0);
    if (m_en) expect_equal("bus_addr_o", last_addr, b);
  endtask

  task automatic run_transfer(input logic [7:0] b);
    send_start();
    check_byte(b);
    send_stop();
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%0d ns: test %s done, %0d errors so far", $time, name, errors);
  endtask

  initial begin
    seed = 32'h8e7c_a64b;
    clk_i = 1'b0;
    rst_i = 1'b1;
    scl_i = 1'b1;
    sda_i = 1'b1;
    cfg_we_i = 1'b0;
    cfg_wdata_i = '0;
    {m_en, m_sta, m_valid} = '0;
    {n_start, n_rstart, n_stop, n_valid} = '0;
    {errors, checks, tests} = '0;
    last_addr = '0;
    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;

    run_transfer(8'hFC);
    write_cfg(1'b0, 7'h2A, 1'b1);
    run_transfer(8'h54);
    expect_counts(0, 0, 0);
    finish_test("reset and disabled");

    write_cfg(1'b1, 7'h2A, 1'b0);
    send_start();
    expect_counts(1, 0, 0);
    check_byte(rand_byte());
    send_start();
    expect_counts(1, 1, 0);
    check_byte(rand_byte());
    send_stop();
    expect_counts(1, 1, 1);
    finish_test("bus conditions");

    data = rand_byte();
    sta = data[6:0];
    write_cfg(1'b1, sta, 1'b1);
    for (int i = 0; i < 16; i++) begin
      data = rand_byte();
      if (i % 2 == 0) data[7:1] = sta;
      run_transfer(data);
    end
    finish_test("address capture and static ACK");

    write_cfg(1'b1, sta, 1'b0);
    for (int i = 0; i < 4; i++) begin
      data = rand_byte();
      data[7:1] = sta;
      run_transfer(data);
    end
    finish_test("static address not valid");

    for (int i = 0; i < 4; i++) begin
      data = rand_byte();
      write_cfg(1'b1, data[6:0], data[7]);
      data = rand_byte();
      data[7:1] = 7'h7E;
      send_start();
      check_byte(data);
      send_start();
      check_byte({7'h7E, ~data[0]});
      send_stop();
    end
    finish_test("broadcast ACK");

    data = rand_byte();
    sta = data[6:0];
    write_cfg(1'b1, sta, 1'b1);
    run_transfer({sta, 1'b0});
    write_cfg(1'b1, sta ^ 7'h15, 1'b1);
    run_transfer({sta, 1'b1});
    run_transfer({sta ^ 7'h15, 1'b0});
    write_cfg(1'b1, sta, 1'b1);
    run_transfer({sta ^ 7'h15, 1'b1});
    finish_test("reconfiguration");

    errors += i_i3c_target.i_i3c_target_props.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* hw/addr_receiver.sv */
////////////////////////////////////////////////////////////////////////////
// Address receiver
// Captures the byte after each START, matches it against the static
// and broadcast addresses and drives the ACK on SDA
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module addr_receiver (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  i3c_target_pkg::target_cfg_t          cfg_i,
  input  i3c_target_pkg::bus_lines_t           lines_i,
  input  logic                                 scl_rise_i,
  input  i3c_target_pkg::bus_cond_t            cond_i,
  output logic                                 sda_o,
  output logic [i3c_target_pkg::ByteWidth-1:0] bus_addr_o,
  output logic                                 bus_addr_valid_o
);

  typedef enum logic [1:0] {
    StIdle,
    StShift,
    StAck,
    StWait
  } state_e;

  state_e state_q;
  logic [$clog2(i3c_target_pkg::ByteWidth)-1:0] cnt_q;
  logic [i3c_target_pkg::ByteWidth-2:0] shift_q;
  logic [i3c_target_pkg::ByteWidth-1:0] byte_next;
  logic [i3c_target_pkg::AddrWidth-1:0] addr_next;
  logic addr_match;
  logic ack_q;
  logic byte_done_q;
  logic scl_prev_q;
  logic scl_fall;
  logic last_bit;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scl_prev_q <= 1'b1;
    end else begin
      scl_prev_q <= lines_i.scl;
    end
  end

  assign scl_fall  = scl_prev_q & ~lines_i.scl;
  assign last_bit  = &cnt_q;
  assign byte_next = {shift_q, lines_i.sda};
  assign addr_next = byte_next[i3c_target_pkg::ByteWidth-1 -: i3c_target_pkg::AddrWidth];

  // Broadcast always, static address only when valid
  assign addr_match = (addr_next == i3c_target_pkg::BroadcastAddr) ||
                      (cfg_i.sta_addr_valid && (addr_next == cfg_i.sta_addr));

  // MSB first
  always_ff @(posedge clk_i) begin
    if (state_q == StShift && scl_rise_i) begin
      shift_q <= byte_next[i3c_target_pkg::ByteWidth-2:0];
      if (last_bit) begin
        bus_addr_o <= byte_next;
        ack_q      <= addr_match;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || !cfg_i.enable) begin
      state_q          <= StIdle;
      cnt_q            <= '0;
      sda_o            <= 1'b1;
      byte_done_q      <= 1'b0;
      bus_addr_valid_o <= 1'b0;
    end else begin
      byte_done_q      <= 1'b0;
      bus_addr_valid_o <= byte_done_q;
      if (cond_i.stop) begin
        state_q <= StIdle;
        sda_o   <= 1'b1;
      end else if (cond_i.start || cond_i.rstart) begin
        state_q <= StShift;
        cnt_q   <= '0;
        sda_o   <= 1'b1;
      end else begin
        unique case (state_q)
          StShift: begin
            if (scl_rise_i) begin
              // Counter wraps to zero after the eighth bit
              cnt_q <= cnt_q + 1'b1;
              if (last_bit) begin
                byte_done_q <= 1'b1;
                state_q     <= StAck;
              end
            end
          end
          StAck: begin
            if (scl_fall) begin
              if (cnt_q == '0) begin
                cnt_q <= cnt_q + 1'b1;
                sda_o <= ~ack_q;
              end else begin
                // End of ACK bit, release SDA
                sda_o   <= 1'b1;
                state_q <= StWait;
              end
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

/* hw/bus_monitor.sv */
////////////////////////////////////////////////////////////////////////////
// Bus monitor
// SCL/SDA synchronizers, SCL rise detection and
// START, repeated START and STOP detection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_monitor (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         scl_i,
  input  logic                         sda_i,
  input  i3c_target_pkg::target_cfg_t  cfg_i,
  output i3c_target_pkg::bus_lines_t   lines_o,
  output logic                         scl_rise_o,
  output i3c_target_pkg::bus_cond_t    cond_o
);

  logic [i3c_target_pkg::SyncStages-1:0] scl_sync;
  logic [i3c_target_pkg::SyncStages-1:0] sda_sync;
  logic scl_s;
  logic sda_s;
  logic scl_q;
  logic sda_q;
  logic start_det;
  logic stop_det;
  logic busy_q;

  assign scl_s = scl_sync[i3c_target_pkg::SyncStages-1];
  assign sda_s = sda_sync[i3c_target_pkg::SyncStages-1];

  // Idle bus is high on both lines
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scl_sync <= '1;
      sda_sync <= '1;
      scl_q    <= 1'b1;
      sda_q    <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[i3c_target_pkg::SyncStages-2:0], scl_i};
      sda_sync <= {sda_sync[i3c_target_pkg::SyncStages-2:0], sda_i};
      scl_q    <= scl_s;
      sda_q    <= sda_s;
    end
  end

  // SDA edges while SCL stays high
  assign start_det = scl_q & scl_s & sda_q & ~sda_s;
  assign stop_det  = scl_q & scl_s & ~sda_q & sda_s;

  always_ff @(posedge clk_i) begin
    if (rst_i || !cfg_i.enable) begin
      cond_o     <= '0;
      scl_rise_o <= 1'b0;
      busy_q     <= 1'b0;
    end else begin
      cond_o.start  <= start_det & ~busy_q;
      // No STOP since the last START
      cond_o.rstart <= start_det & busy_q;
      cond_o.stop   <= stop_det;
      scl_rise_o    <= scl_s & ~scl_q;
      if (start_det) begin
        busy_q <= 1'b1;
      end else if (stop_det) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Aligned with the registered pulses
  assign lines_o.scl = scl_q;
  assign lines_o.sda = sda_q;

endmodule

/* hw/i3c_target.sv */
////////////////////////////////////////////////////////////////////////////
// I3C/I2C target top level
// Configuration register, bus monitor and address receiver
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module i3c_target (
  input  logic                                 clk_i,
  input  logic                                 rst_i,

  // Bus pins
  input  logic                                 scl_i,
  input  logic                                 sda_i,
  output logic                                 scl_o,
  output logic                                 sda_o,

  // Configuration write
  input  logic                                 cfg_we_i,
  input  logic [i3c_target_pkg::CfgWidth-1:0]  cfg_wdata_i,

  // Bus conditions and received address
  output logic                                 bus_start_o,
  output logic                                 bus_rstart_o,
  output logic                                 bus_stop_o,
  output logic [i3c_target_pkg::ByteWidth-1:0] bus_addr_o,
  output logic                                 bus_addr_valid_o
);

  i3c_target_pkg::target_cfg_t cfg;
  i3c_target_pkg::bus_lines_t  lines;
  i3c_target_pkg::bus_cond_t   cond;
  logic                        scl_rise;

  target_config xtarget_config (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_wdata_i(cfg_wdata_i),
    .cfg_o      (cfg)
  );

  bus_monitor xbus_monitor (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .scl_i     (scl_i),
    .sda_i     (sda_i),
    .cfg_i     (cfg),
    .lines_o   (lines),
    .scl_rise_o(scl_rise),
    .cond_o    (cond)
  );

  addr_receiver xaddr_receiver (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .cfg_i           (cfg),
    .lines_i         (lines),
    .scl_rise_i      (scl_rise),
    .cond_i          (cond),
    .sda_o           (sda_o),
    .bus_addr_o      (bus_addr_o),
    .bus_addr_valid_o(bus_addr_valid_o)
  );

  // Target never stretches the clock
  assign scl_o = 1'b1;

  assign bus_start_o  = cond.start;
  assign bus_rstart_o = cond.rstart;
  assign bus_stop_o   = cond.stop;

endmodule

/* hw/i3c_target_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the I3C/I2C target side
// Bus constants, configuration word layout, bus line, bus condition
// and target configuration structs
////////////////////////////////////////////////////////////////////////////

package i3c_target_pkg;

  // Bus constants
  localparam int unsigned AddrWidth = 7;
  localparam int unsigned ByteWidth = 8;

  // I3C broadcast address, always acknowledged
  localparam logic [AddrWidth-1:0] BroadcastAddr = 7'h7E;

  // Configuration word layout
  localparam int unsigned CfgWidth = 32;
  localparam int unsigned CfgEnBit = 0;
  localparam int unsigned CfgStaAddrLsb = 8;
  localparam int unsigned CfgStaValidBit = 15;

  // Flops per bus line ahead of edge detection
  localparam int unsigned SyncStages = 2;

  // Synchronized SCL/SDA levels
  typedef struct packed {
    logic scl;
    logic sda;
  } bus_lines_t;

  // One-cycle bus condition pulses
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_cond_t;

  // Decoded target configuration
  typedef struct packed {
    logic                 enable;
    logic [AddrWidth-1:0] sta_addr;
    logic                 sta_addr_valid;
  } target_cfg_t;

endpackage

/* hw/target_config.sv */
////////////////////////////////////////////////////////////////////////////
// Target configuration register
// Word written by strobe, decoded into enable and static address fields
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module target_config (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  cfg_we_i,
  input  logic [i3c_target_pkg::CfgWidth-1:0]   cfg_wdata_i,
  output i3c_target_pkg::target_cfg_t           cfg_o
);

  logic [i3c_target_pkg::CfgWidth-1:0] cfg_q;

  // Cleared word leaves the target disabled
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_q <= '0;
    end else if (cfg_we_i) begin
      cfg_q <= cfg_wdata_i;
    end
  end

  // Field decode
  assign cfg_o.enable = cfg_q[i3c_target_pkg::CfgEnBit];
  assign cfg_o.sta_addr =
      cfg_q[i3c_target_pkg::CfgStaAddrLsb +: i3c_target_pkg::AddrWidth];
  assign cfg_o.sta_addr_valid = cfg_q[i3c_target_pkg::CfgStaValidBit];

endmodule
